// File: project.f
+incdir+src
src/vmem_cfg_pkg.sv
src/vmem_bus_pkg.sv
src/vmem_ifs.sv
src/vaddr_generator.sv
src/address_scheduler.sv
src/lane_bank.sv
src/load_collector.sv
src/vector_mem_unit.sv
verification/vector_mem_unit_chk.sv
verification/vector_mem_unit_tb.sv

// File: Bender.yml
package:
  name: vector_mem_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/vmem_cfg_pkg.sv
      - src/vmem_bus_pkg.sv
      - src/vmem_ifs.sv
      - src/vaddr_generator.sv
      - src/address_scheduler.sv
      - src/lane_bank.sv
      - src/load_collector.sv
      - src/vector_mem_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/vector_mem_unit_chk.sv
      - verification/vector_mem_unit_tb.sv

// File: verification/vector_mem_unit_tb.sv
// directed tests of the vector memory stage against a byte model of the lane banks
`timescale 1ns/1ps
`include "vmem_defs.svh"

module vector_mem_unit_tb import vmem_cfg_pkg::*, vmem_bus_pkg::*; ();

  localparam int LANES      = `VMEM_LANES;
  localparam int VLMAX      = 2*LANES;
  localparam int W          = `VMEM_WORD_W;
  localparam int VEC_W      = VLMAX*W;
  localparam int BANK_BYTES = `VMEM_BANK_WORDS*(W/8);
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;
  localparam int OP_LIMIT   = 20;    // cycles from accepted start to done or exception
  localparam int NUM_OPS    = 69;    // 2 + 28 + 4 + 32 + 3 over the five tests
  // one gap cycle per op plus the idle watch in the ignored-start test
  localparam int TIMEOUT_CYCLES = RST_CYCLES + NUM_OPS*(OP_LIMIT+1) + 16;

  // one vector operation as seen on the top-level ports
  typedef struct packed {
    vop_t   op;
    sew_t   sew;
    laddr_t base;
    laddr_t stride;
    vlen_t  vl;
  } op_t;

  logic             CLK;
  logic             nRST;
  logic             start;
  vop_t             op;
  sew_t             sew;
  laddr_t           base;
  laddr_t           stride;
  vlen_t            vl;
  logic [VEC_W-1:0] store_vec;
  logic             busy;
  logic             done;
  logic             exception;
  logic [VEC_W-1:0] load_vec;

  logic [7:0] bank_model [LANES][BANK_BYTES];   // per-lane byte image of the banks
  word_t      stim [VLMAX];                      // store data with element i at index i
  integer     seed;
  int         cycle_count = 0;

  vector_mem_unit dut_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start),
    .op        (op),
    .sew       (sew),
    .base      (base),
    .stride    (stride),
    .vl        (vl),
    .store_vec (store_vec),
    .busy      (busy),
    .done      (done),
    .exception (exception),
    .load_vec  (load_vec)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(CLK_PERIOD/2) CLK = ~CLK;
  end

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic value_error(input string msg);
    fail_now($sformatf("Error at %0t ns: %s", $time, msg));
  endtask

  always @(posedge CLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      fail_now("simulation ran past its cycle limit without finishing the tests");
    else if (dut_i.chk_i.fail_count != 0)
      fail_now("a handshake assertion in the bound checker failed");
  end

  function automatic op_t make_op(vop_t o, sew_t s, int b, int st, int v);
    op_t c;
    c.op     = o;
    c.sew    = s;
    c.base   = laddr_t'(b);
    c.stride = laddr_t'(st);
    c.vl     = vlen_t'(v);
    return c;
  endfunction

  // byte address of element i wrapped into the lane address space
  function automatic int elem_addr(op_t c, int i);
    return ((int'(c.base) + int'(c.stride)*i) % (1 << `VMEM_ADDR_W)) % BANK_BYTES;
  endfunction

  function automatic logic [VEC_W-1:0] pack_stim();
    logic [VEC_W-1:0] v;
    int i;
    for (i = 0; i < VLMAX; i++)
      v[i*W +: W] = stim[i];
    return v;
  endfunction

  task automatic new_stim();
    int i;
    for (i = 0; i < VLMAX; i++)
      stim[i] = $random(seed);
  endtask

  // lane k takes elements k and k+LANES in order and stops at a misaligned one
  task automatic model_op(input op_t c, output logic exp_ex, output logic [VEC_W-1:0] exp_vec);
    int    nb;
    int    k;
    int    j;
    int    b;
    int    i;
    int    a;
    logic  lane_ok;
    word_t val;
    nb      = (c.sew == SEW8) ? 1 : (c.sew == SEW16) ? 2 : 4;
    exp_ex  = 1'b0;
    exp_vec = '0;                                // inactive slots read zero
    for (k = 0; k < LANES; k++)
    begin
      lane_ok = 1'b1;
      for (j = 0; j < 2; j++)
      begin
        i = k + j*LANES;
        a = elem_addr(c, i);
        if (lane_ok && i < int'(c.vl))
        begin
          if (a % nb != 0)
          begin
            lane_ok = 1'b0;                      // later element never issued
            exp_ex  = 1'b1;
          end
          else if (c.op == VOP_STORE)
          begin
            for (b = 0; b < nb; b++)
              bank_model[k][a+b] = stim[i][b*8 +: 8];
          end
          else
          begin
            val = '0;                            // zero-extended element
            for (b = 0; b < nb; b++)
              val[b*8 +: 8] = bank_model[k][a+b];
            exp_vec[i*W +: W] = val;
          end
        end
      end
    end
  endtask

  // start is held through one rising edge and the task returns at the negedge of T+1
  task automatic drive_start(input op_t c);
    op        = c.op;
    sew       = c.sew;
    base      = c.base;
    stride    = c.stride;
    vl        = c.vl;
    store_vec = pack_stim();
    start     = 1'b1;
    @(negedge CLK);
    start     = 1'b0;
  endtask

  task automatic wait_end(input int first, output int cycles, output logic got_ex);
    cycles = first;
    while (!done && !exception)
    begin
      assert (busy) else value_error("busy low while an operation is running");
      if (cycles >= OP_LIMIT)
        fail_now($sformatf("no done or exception within %0d cycles of a start", OP_LIMIT));
      @(negedge CLK);
      cycles++;
    end
    got_ex = exception;
  endtask

  // one operation with an optional second start pulsed at T+2 while busy
  task automatic run_op(input op_t c, input op_t intruder, input bit with_intruder,
                        output int cycles);
    logic             exp_ex;
    logic             got_ex;
    logic [VEC_W-1:0] exp_vec;
    int               first;
    @(negedge CLK);                              // busy has fallen after the last end
    assert (!busy) else value_error("busy high between operations");
    model_op(c, exp_ex, exp_vec);
    drive_start(c);
    first = 1;
    if (with_intruder)
    begin
      @(negedge CLK);
      new_stim();                                // different data on the ignored start
      drive_start(intruder);
      first = 3;
    end
    wait_end(first, cycles, got_ex);
    assert (!(done && exception)) else value_error("done and exception high together");
    assert (got_ex == exp_ex)
      else value_error($sformatf("exception %0b, expected %0b", got_ex, exp_ex));
    if (c.op == VOP_LOAD && !exp_ex)
      assert (load_vec == exp_vec)
        else value_error($sformatf("load_vec %h, expected %h", load_vec, exp_vec));
  endtask

  // stride 0 makes every lane write the same word
  task automatic fill_region(input int first_addr, input int nwords);
    int w;
    int cycles;
    for (w = 0; w < nwords; w++)
    begin
      new_stim();
      run_op(make_op(VOP_STORE, SEW32, first_addr + 4*w, 0, VLMAX), '0, 1'b0, cycles);
    end
  endtask

  task automatic check_region(input int first_addr, input int nwords);
    int w;
    int cycles;
    for (w = 0; w < nwords; w++)
      run_op(make_op(VOP_LOAD, SEW32, first_addr + 4*w, 0, VLMAX), '0, 1'b0, cycles);
  endtask

  task automatic test_word_roundtrip();
    op_t c;
    int  cycles;
    c = make_op(VOP_STORE, SEW32, 'h040, 4, VLMAX);
    new_stim();
    run_op(c, '0, 1'b0, cycles);
    assert (cycles == 6) else value_error($sformatf("store took %0d cycles, not 6", cycles));
    c.op = VOP_LOAD;
    run_op(c, '0, 1'b0, cycles);
    assert (cycles == 6) else value_error($sformatf("load took %0d cycles, not 6", cycles));
    assert (load_vec == pack_stim()) else value_error("load_vec differs from stored vector");
  endtask

  task automatic test_narrow();
    int cycles;
    int i;
    fill_region('h200, 12);
    new_stim();
    run_op(make_op(VOP_STORE, SEW16, 'h200, 6, VLMAX), '0, 1'b0, cycles);  // three halfwords apart
    new_stim();
    run_op(make_op(VOP_STORE, SEW8, 'h201, 3, VLMAX), '0, 1'b0, cycles);
    run_op(make_op(VOP_LOAD, SEW8, 'h201, 3, VLMAX), '0, 1'b0, cycles);
    for (i = 0; i < VLMAX; i++)
      assert (load_vec[i*W+8 +: W-8] == '0)
        else value_error($sformatf("byte element %0d not zero-extended", i));
    run_op(make_op(VOP_LOAD, SEW16, 'h200, 6, VLMAX), '0, 1'b0, cycles);
    check_region('h200, 12);                     // untouched bytes keep the fill
  endtask

  task automatic test_short_vl();
    int cycles;
    new_stim();
    run_op(make_op(VOP_STORE, SEW32, 'h300, 4, VLMAX), '0, 1'b0, cycles);
    new_stim();
    run_op(make_op(VOP_STORE, SEW32, 'h300, 4, 5), '0, 1'b0, cycles);      // 5..7 keep old data
    run_op(make_op(VOP_LOAD, SEW32, 'h300, 4, VLMAX), '0, 1'b0, cycles);
    run_op(make_op(VOP_LOAD, SEW32, 'h300, 4, 3), '0, 1'b0, cycles);
    assert (load_vec[VEC_W-1:3*W] == '0) else value_error("slots at or beyond vl not zero");
  endtask

  task automatic test_misaligned();
    int cycles;
    fill_region('h380, 10);
    new_stim();
    run_op(make_op(VOP_STORE, SEW32, 'h380, 6, VLMAX), '0, 1'b0, cycles);  // odd elements fault
    check_region('h380, 10);                     // even lanes' writes stay
    new_stim();
    run_op(make_op(VOP_STORE, SEW16, 'h380, 3, VLMAX), '0, 1'b0, cycles);
    check_region('h380, 10);
  endtask

  task automatic test_ignored_start();
    op_t a;
    int  cycles;
    a = make_op(VOP_STORE, SEW32, 'h080, 4, VLMAX);
    new_stim();
    run_op(a, make_op(VOP_STORE, SEW32, 'h080, 4, VLMAX), 1'b1, cycles);
    assert (cycles == 6) else value_error($sformatf("store took %0d cycles, not 6", cycles));
    repeat (8)
    begin
      @(negedge CLK);
      assert (!done && !exception) else value_error("second end after an ignored start");
    end
    a.op = VOP_LOAD;
    run_op(a, '0, 1'b0, cycles);                 // first store's data only
    run_op(a, make_op(VOP_LOAD, SEW8, 'h081, 1, 3), 1'b1, cycles);
  endtask

  initial
  begin
    seed      = 32'habff0d1a;
    nRST      = 1'b0;
    start     = 1'b0;
    op        = VOP_LOAD;
    sew       = SEW8;
    base      = '0;
    stride    = '0;
    vl        = '0;
    store_vec = '0;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    test_word_roundtrip();
    test_narrow();
    test_short_vl();
    test_misaligned();
    test_ignored_start();
    repeat (2) @(negedge CLK);                   // let the bound checker see the last end
    if (dut_i.chk_i.fail_count == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("Error at %0t ns: %0d handshake assertions failed", $time,
               dut_i.chk_i.fail_count);
      $display("STATUS: FAIL");
      $fatal(1, "handshake checker reported failures");
    end
  end

endmodule

// File: verification/vector_mem_unit_chk.sv
// handshake checker bound into the vector memory top level, watches done, exception and busy
`timescale 1ns/1ps

module vector_mem_unit_chk (
  input logic CLK,
  input logic nRST,
  input logic busy,
  input logic done,
  input logic exception
);

  int unsigned fail_count = 0;   // failed assertions so far

  // an operation ends one way only
  a_single_end: assert property (@(posedge CLK) disable iff (!nRST) !(done && exception))
    else
    begin
      $error("done and exception high in the same cycle");
      fail_count++;
    end

  a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST) done |=> !done)
    else
    begin
      $error("done held longer than one cycle");
      fail_count++;
    end

  a_ex_pulse: assert property (@(posedge CLK) disable iff (!nRST) exception |=> !exception)
    else
    begin
      $error("exception held longer than one cycle");
      fail_count++;
    end

  // busy falls together with the end strobe
  a_busy_drops: assert property (@(posedge CLK) disable iff (!nRST)
                                 (done || exception) |=> !busy)
    else
    begin
      $error("busy still high after the end of an operation");
      fail_count++;
    end

endmodule

bind vector_mem_unit vector_mem_unit_chk chk_i (
  .CLK       (CLK),
  .nRST      (nRST),
  .busy      (busy),
  .done      (done),
  .exception (exception)
);

// File: src/vector_mem_unit.sv
// top of the vector memory stage: address generator, one scheduler and bank per lane, collector
`timescale 1ns/1ps
`include "vmem_defs.svh"

module vector_mem_unit import vmem_cfg_pkg::*, vmem_bus_pkg::*; (
  input  logic   CLK,
  input  logic   nRST,
  input  logic   start,
  input  vop_t   op,
  input  sew_t   sew,
  input  laddr_t base,
  input  laddr_t stride,
  input  vlen_t  vl,
  input  logic [2*`VMEM_LANES*`VMEM_WORD_W-1:0] store_vec,   // element i at word i
  output logic   busy,
  output logic   done,
  output logic   exception,
  output logic [2*`VMEM_LANES*`VMEM_WORD_W-1:0] load_vec
);

  lane_cmd_if cmd_if [`VMEM_LANES] ();
  lane_rsp_if rsp_if [`VMEM_LANES] ();
  lane_mem_if mem_if [`VMEM_LANES] ();

  vaddr_generator gen_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start),
    .op        (op),
    .sew       (sew),
    .base      (base),
    .stride    (stride),
    .vl        (vl),
    .store_vec (store_vec),
    .busy      (busy),
    .cmd       (cmd_if)
  );

  for (genvar k = 0; k < `VMEM_LANES; k++)
  begin : g_lane
    address_scheduler sched_i (
      .CLK  (CLK),
      .nRST (nRST),
      .cmd  (cmd_if[k]),
      .rsp  (rsp_if[k]),
      .mem  (mem_if[k])
    );

    lane_bank bank_i (
      .CLK  (CLK),
      .nRST (nRST),
      .mem  (mem_if[k])
    );
  end

  load_collector coll_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .go        (cmd_if[0].go),   // all lanes get the same go
    .rsp       (rsp_if),
    .busy      (busy),
    .done      (done),
    .exception (exception),
    .load_vec  (load_vec)
  );

endmodule

// File: src/load_collector.sv
// gathers lane load results into one vector and closes each operation with done or exception
`timescale 1ns/1ps
`include "vmem_defs.svh"

module load_collector import vmem_bus_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      go,                  // lane 0 copy of the start strobe
  lane_rsp_if.coll  rsp [`VMEM_LANES],
  output logic      busy,
  output logic      done,
  output logic      exception,
  output logic [2*`VMEM_LANES*`VMEM_WORD_W-1:0] load_vec
);

  logic                   busy_q;
  logic                   finish;
  logic [`VMEM_LANES-1:0] lane_busy;
  logic [`VMEM_LANES-1:0] lane_ex;

  // lanes are not busy yet in the go cycle, so it never finishes
  assign finish    = busy_q & ~go & ~|lane_busy;
  assign done      = finish & ~|lane_ex;
  assign exception = finish & |lane_ex;
  assign busy      = go | busy_q;        // high from the cycle after the start

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      busy_q <= 1'b0;
    else if (go)
      busy_q <= 1'b1;
    else if (finish)
      busy_q <= 1'b0;
  end

  for (genvar k = 0; k < `VMEM_LANES; k++)
  begin : g_lane
    word_t slot0_q, slot1_q;             // elements k and k + lanes

    assign lane_busy[k]    = rsp[k].busy;
    assign lane_ex[k]      = rsp[k].exception;
    assign rsp[k].returnex = exception;  // every lane leaves EX together

    always_ff @(posedge CLK)
    begin
      if (go)
      begin
        slot0_q <= '0;                   // skipped elements read zero
        slot1_q <= '0;
      end
      else
      begin
        if (rsp[k].arrived0)
          slot0_q <= rsp[k].loaddata0;
        if (rsp[k].arrived1)
          slot1_q <= rsp[k].loaddata1;
      end
    end

    assign load_vec[k*`VMEM_WORD_W +: `VMEM_WORD_W]               = slot0_q;
    assign load_vec[(k+`VMEM_LANES)*`VMEM_WORD_W +: `VMEM_WORD_W] = slot1_q;
  end

endmodule

// File: src/lane_bank.sv
// private word memory of one lane, answers each request with dhit one cycle after sampling it
`timescale 1ns/1ps
`include "vmem_defs.svh"

module lane_bank import vmem_bus_pkg::*; (
  input logic      CLK,
  input logic      nRST,
  lane_mem_if.bank mem
);

  localparam int NB    = `VMEM_WORD_W/8;           // bytes per word
  localparam int OFF_W = $clog2(NB);
  localparam int IDX_W = $clog2(`VMEM_BANK_WORDS);

  word_t            words [`VMEM_BANK_WORDS];
  word_t            rdata_q;
  logic             seen_q;     // request sampled last cycle
  logic             sample;
  logic [IDX_W-1:0] idx;
  logic [OFF_W-1:0] off;
  logic [NB-1:0]    be;

  assign idx    = mem.final_addr[OFF_W +: IDX_W];
  assign off    = mem.final_addr[OFF_W-1:0];
  assign sample = (mem.ren | mem.wen) & ~seen_q;   // idle one cycle after every hit

  // byte lanes touched by this access
  always_comb
  begin
    case (mem.byte_ena)
      BE_BYTE: be = NB'(1) << off;
      BE_HALF: be = NB'(3) << off;
      default: be = '1;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      seen_q <= 1'b0;
    else
      seen_q <= sample;
  end

  always_ff @(posedge CLK)
  begin
    if (sample)
      rdata_q <= words[idx];                       // shown during dhit
    if (mem.wen & seen_q)                          // write lands on the hit cycle
    begin
      for (int b = 0; b < NB; b++)
        if (be[b])
          words[idx][b*8 +: 8] <= mem.final_storedata[b*8 +: 8];
    end
  end

  assign mem.dhit  = seen_q;
  assign mem.rdata = rdata_q;

endmodule

// File: src/address_scheduler.sv
// one lane's sequencer: two bank accesses in order, alignment check, load element extraction
`timescale 1ns/1ps
`include "vmem_defs.svh"

module address_scheduler import vmem_cfg_pkg::*, vmem_bus_pkg::*; (
  input logic       CLK,
  input logic       nRST,
  lane_cmd_if.sched cmd,
  lane_rsp_if.sched rsp,
  lane_mem_if.sched mem
);

  localparam int OFF_W = $clog2(`VMEM_WORD_W/8);  // byte offset bits inside a word

  typedef enum logic [1:0] {IDLE, ACC0, ACC1, EX} state_t;

  state_t state, next_state;
  vop_t   op_q;                 // op of the running operation
  logic   mis0, mis1;
  laddr_t cur_addr;
  word_t  cur_store;
  logic [OFF_W-1:0] off;
  word_t  shifted;
  word_t  elem;
  logic   in_acc;
  logic   is_load;

  // alignment to the element width
  function automatic logic misaligned(laddr_t a, sew_t s);
    case (s)
      SEW16:   return a[0];
      SEW32:   return |a[1:0];
      default: return 1'b0;
    endcase
  endfunction

  assign mis0 = cmd.active0 & misaligned(cmd.addr0, cmd.sew);  // inactive never faults
  assign mis1 = cmd.active1 & misaligned(cmd.addr1, cmd.sew);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state <= IDLE;
      op_q  <= VOP_LOAD;
    end
    else
    begin
      state <= next_state;
      if (cmd.go)
        op_q <= cmd.op;
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        if (cmd.go)
        begin
          if (cmd.active0)
            next_state = mis0 ? EX : ACC0;
          else if (cmd.active1)
            next_state = mis1 ? EX : ACC1;   // element 0 skipped, no bank request
        end
      end
      ACC0:
      begin
        if (mem.dhit)
        begin
          if (cmd.active1)
            next_state = mis1 ? EX : ACC1;   // first write already done
          else
            next_state = IDLE;
        end
      end
      ACC1:
      begin
        if (mem.dhit)
          next_state = IDLE;
      end
      EX:
      begin
        if (rsp.returnex)
          next_state = IDLE;                 // released by the collector
      end
      default: next_state = IDLE;
    endcase
  end

  assign in_acc    = (state == ACC0) | (state == ACC1);
  assign is_load   = op_q == VOP_LOAD;
  assign cur_addr  = (state == ACC1) ? cmd.addr1 : cmd.addr0;
  assign cur_store = (state == ACC1) ? cmd.storedata1 : cmd.storedata0;
  assign off       = cur_addr[OFF_W-1:0];

  // request stays up through the dhit cycle
  assign mem.ren             = in_acc & is_load;
  assign mem.wen             = in_acc & ~is_load;
  assign mem.final_addr      = cur_addr;
  assign mem.final_storedata = cur_store << {off, 3'b000};     // element to its byte lanes
  assign mem.byte_ena        = (cmd.sew == SEW8)  ? BE_BYTE :
                               (cmd.sew == SEW16) ? BE_HALF : BE_WORD;

  // load path, shift down and zero-extend
  assign shifted = mem.rdata >> {off, 3'b000};

  always_comb
  begin
    case (cmd.sew)
      SEW8:    elem = word_t'(shifted[7:0]);
      SEW16:   elem = word_t'(shifted[15:0]);
      default: elem = shifted;
    endcase
  end

  assign rsp.arrived0  = (state == ACC0) & mem.dhit & is_load;
  assign rsp.arrived1  = (state == ACC1) & mem.dhit & is_load;
  assign rsp.loaddata0 = elem;    // same bus for both, strobes tell them apart
  assign rsp.loaddata1 = elem;
  assign rsp.busy      = in_acc;
  assign rsp.exception = state == EX;

endmodule

// File: src/vaddr_generator.sv
// latches an accepted start and hands every lane its two element addresses, flags and data
`timescale 1ns/1ps
`include "vmem_defs.svh"

module vaddr_generator import vmem_cfg_pkg::*, vmem_bus_pkg::*; (
  input  logic   CLK,
  input  logic   nRST,
  input  logic   start,
  input  vop_t   op,
  input  sew_t   sew,
  input  laddr_t base,
  input  laddr_t stride,
  input  vlen_t  vl,
  input  logic [2*`VMEM_LANES*`VMEM_WORD_W-1:0] store_vec,
  input  logic   busy,                  // from the collector
  lane_cmd_if.gen cmd [`VMEM_LANES]
);

  logic accept;
  logic go_q;
  vop_t op_q;
  sew_t sew_q;

  assign accept = start & ~busy;        // a start during an operation is dropped

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      go_q  <= 1'b0;
      op_q  <= VOP_LOAD;
      sew_q <= SEW8;
    end
    else
    begin
      go_q <= accept;                   // go one cycle after the start
      if (accept)
      begin
        op_q  <= op;
        sew_q <= sew;
      end
    end
  end

  for (genvar k = 0; k < `VMEM_LANES; k++)
  begin : g_lane
    laddr_t addr0_q, addr1_q;
    logic   act0_q, act1_q;
    word_t  sd0_q, sd1_q;

    // active flags, cleared so an idle unit never sees stale elements
    always_ff @(posedge CLK, negedge nRST)
    begin
      if (!nRST)
      begin
        act0_q <= 1'b0;
        act1_q <= 1'b0;
      end
      else if (accept)
      begin
        act0_q <= vlen_t'(k) < vl;
        act1_q <= vlen_t'(k + `VMEM_LANES) < vl;
      end
    end

    always_ff @(posedge CLK)
    begin
      if (accept)
      begin
        addr0_q <= base + stride * laddr_t'(k);                  // wraps in the bank
        addr1_q <= base + stride * laddr_t'(k + `VMEM_LANES);
        sd0_q   <= store_vec[k*`VMEM_WORD_W +: `VMEM_WORD_W];
        sd1_q   <= store_vec[(k+`VMEM_LANES)*`VMEM_WORD_W +: `VMEM_WORD_W];
      end
    end

    assign cmd[k].go         = go_q;
    assign cmd[k].op         = op_q;
    assign cmd[k].sew        = sew_q;
    assign cmd[k].addr0      = addr0_q;
    assign cmd[k].addr1      = addr1_q;
    assign cmd[k].active0    = act0_q;
    assign cmd[k].active1    = act1_q;
    assign cmd[k].storedata0 = sd0_q;
    assign cmd[k].storedata1 = sd1_q;
  end

endmodule

// File: src/vmem_ifs.sv
// lane interfaces: generator to scheduler, scheduler to collector, scheduler to bank
`timescale 1ns/1ps
`include "vmem_defs.svh"

// per-lane command, held stable by the generator for the whole operation
interface lane_cmd_if import vmem_cfg_pkg::*, vmem_bus_pkg::*; ();
  logic   go;          // one-cycle strobe, lane starts on it
  vop_t   op;
  sew_t   sew;
  laddr_t addr0;       // element k
  laddr_t addr1;       // element k + lanes
  logic   active0;
  logic   active1;
  word_t  storedata0;
  word_t  storedata1;

  modport gen (output go, op, sew, addr0, addr1, active0, active1, storedata0, storedata1);
  modport sched (input go, op, sew, addr0, addr1, active0, active1, storedata0, storedata1);
endinterface

// per-lane status and load results
interface lane_rsp_if import vmem_bus_pkg::*; ();
  logic  arrived0;     // strobe, loaddata0 valid
  logic  arrived1;
  word_t loaddata0;    // already aligned and zero-extended
  word_t loaddata1;
  logic  busy;
  logic  exception;    // level, held until returnex
  logic  returnex;     // strobe from collector, lane back to idle

  modport sched (output arrived0, arrived1, loaddata0, loaddata1, busy, exception,
                 input returnex);
  modport coll (input arrived0, arrived1, loaddata0, loaddata1, busy, exception,
                output returnex);
endinterface

// scheduler to bank, request held until dhit
interface lane_mem_if import vmem_bus_pkg::*; ();
  logic      ren;
  logic      wen;
  laddr_t    final_addr;
  word_t     final_storedata;  // already shifted to its byte lanes
  byte_ena_t byte_ena;
  word_t     rdata;            // valid while dhit
  logic      dhit;

  modport sched (output ren, wen, final_addr, final_storedata, byte_ena,
                 input rdata, dhit);
  modport bank (input ren, wen, final_addr, final_storedata, byte_ena,
                output rdata, dhit);
endinterface

// File: src/vmem_bus_pkg.sv
// bank-access types shared by the lane interfaces, schedulers, banks and collector
`include "vmem_defs.svh"

package vmem_bus_pkg;

  // one bank word, also one element slot of store_vec / load_vec
  typedef logic [`VMEM_WORD_W-1:0] word_t;

  // byte address inside one lane's bank
  typedef logic [`VMEM_ADDR_W-1:0] laddr_t;

  // access size code seen by the bank
  typedef enum logic [1:0] {
    BE_BYTE = 2'd0,
    BE_HALF = 2'd1,
    BE_WORD = 2'd2
  } byte_ena_t;

endpackage

// File: src/vmem_cfg_pkg.sv
// operation-level types for a vector load or store, imported by the generator, lanes and top
`include "vmem_defs.svh"

package vmem_cfg_pkg;

  // element width of one vector operation
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // load or store
  typedef enum logic {
    VOP_LOAD  = 1'b0,
    VOP_STORE = 1'b1
  } vop_t;

  // vector length, 0 up to two elements per lane
  typedef logic [$clog2(2*`VMEM_LANES+1)-1:0] vlen_t;

endpackage

// File: src/vmem_defs.svh
// sizing macros for the vector memory stage, included by every package, interface and module
`ifndef VMEM_DEFS_SVH
`define VMEM_DEFS_SVH

// number of lanes, each with its own bank (2, 4 or 8)
`define VMEM_LANES 4

// lane-local byte address width
`define VMEM_ADDR_W 10

// bank word width, four byte lanes
`define VMEM_WORD_W 32

// words per lane bank
`define VMEM_BANK_WORDS 256

`endif
